//--- bench/tb_wfd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wfd_ctrl import wfd_pkg::*; ();

	localparam int STARTUP_CYCLES = 200;
	localparam int LED_HOLD       = 16;
	localparam int RANDOM_TOKENS  = 8;

	// DUT ports named as on the top level
	logic                  CLK125;
	logic                  rst_n_i;
	logic                  ser_trig_i;
	logic                  ext_rst_n_i;
	logic                  mem_err_i;
	logic                  vme_access_i;
	logic                  cpld_access_i;
	logic                  inhibit_i;
	logic [TOKEN_BITS-1:0] token_o;
	logic                  tok_rdy_o;
	logic                  tok_err_o;
	token_word_t           tx_word_o;
	logic                  tx_k_o;
	logic                  sys_rst_o;
	logic [LED_COUNT-1:0]  led_o;

	// Error counts and cycle count
	int mismatch_cnt = 0;
	int other_cnt    = 0;
	int cyc          = 0;
	int err_led_due  = -1;
	int trig_led_due = -1;
	int seed         = 32'h152676d4;

	// Frames on the line with the oldest first
	logic [15:0] exp_word_q[$];
	int          exp_due_q[$];
	string       exp_name_q[$];

	wfd_ctrl_top #(
		.STARTUP_CYCLES (STARTUP_CYCLES),
		.LED_HOLD       (LED_HOLD)
	) u_wfd_ctrl_top (.*);

	initial begin
		CLK125 = 1'b0;
		forever #2 CLK125 = ~CLK125;
	end

	always @(posedge CLK125) begin
		cyc <= cyc + 1;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		mismatch_cnt++;
		$display("CHECK FAILED %0s: expected %h, actual %h", name, exp_v, act_v);
	endtask

	// Ready cycle against the oldest frame sent
	task automatic check_frame(input string name, input logic [15:0] word, input int due);
		token_word_t exp_w;
		exp_w.raw = word;
		if (cyc != due) begin
			report_mismatch({name, " ready cycle"}, due, cyc);
		end
		if (token_o !== exp_w.frame.token) begin
			report_mismatch({name, " token"}, exp_w.frame.token, token_o);
		end
		if (tok_err_o !== exp_w.frame.err) begin
			report_mismatch({name, " parity error"}, exp_w.frame.err, tok_err_o);
		end
		if (tx_k_o !== 1'b0 || tx_word_o.raw !== exp_w.raw) begin
			report_mismatch({name, " link word"}, {1'b0, exp_w.raw}, {tx_k_o, tx_word_o.raw});
		end
		// Every token lights the trigger LED two cycles on
		trig_led_due = cyc + 2;
		// Bad token lights the error LED two cycles on
		if (exp_w.frame.err) begin
			err_led_due = cyc + 2;
		end
	endtask

	//////////////////////////////
	// Link monitor
	//////////////////////////////

	always @(negedge CLK125) begin
		if (rst_n_i === 1'b1) begin
			if (tok_rdy_o === 1'b1) begin
				if (exp_word_q.size() == 0) begin
					other_cnt++;
					$display("ERROR: ready pulse with no frame sent, cycle %0d", cyc);
				end else begin
					check_frame(exp_name_q.pop_front(), exp_word_q.pop_front(),
						exp_due_q.pop_front());
				end
			end else begin
				// Idle comma in every other cycle
				if (tx_k_o !== 1'b1 || tx_word_o.raw !== IDLE_COMMA) begin
					report_mismatch("idle link word", {1'b1, IDLE_COMMA},
						{tx_k_o, tx_word_o.raw});
				end
				if (exp_due_q.size() != 0 && exp_due_q[0] < cyc) begin
					other_cnt++;
					$display("ERROR: no ready pulse for %0s", exp_name_q[0]);
					void'(exp_name_q.pop_front());
					void'(exp_word_q.pop_front());
					void'(exp_due_q.pop_front());
				end
			end
			if (cyc == err_led_due && led_o[LED_ERR] !== 1'b1) begin
				report_mismatch("error LED after bad token", 1, led_o[LED_ERR]);
			end
			if (cyc == trig_led_due && led_o[LED_TRIG] !== 1'b1) begin
				report_mismatch("trigger LED after token", 1, led_o[LED_TRIG]);
			end
		end
	end

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	// Start bit, token MSB first, odd parity, one idle cycle
	task automatic send_frame(input string name, input logic [TOKEN_BITS-1:0] tok,
			input logic bad_par, input logic [15:0] word);
		logic par;
		int   i;
		par = ~(^tok) ^ bad_par;
		@(posedge CLK125);
		ser_trig_i <= 1'b1;
		for (i = TOKEN_BITS - 1; i >= 0; i--) begin
			@(posedge CLK125);
			ser_trig_i <= tok[i];
		end
		@(posedge CLK125);
		ser_trig_i <= par;
		@(negedge CLK125);
		exp_word_q.push_back(word);
		exp_due_q.push_back(cyc + 2);
		exp_name_q.push_back(name);
		@(posedge CLK125);
		ser_trig_i <= 1'b0;
	endtask

	// System reset follows the CPLD line two cycles late
	task automatic apply_ext_reset(input string name, input logic level, input logic exp_rst);
		logic prev;
		@(negedge CLK125);
		prev = sys_rst_o;
		@(posedge CLK125);
		ext_rst_n_i <= level;
		@(negedge CLK125);
		@(negedge CLK125);
		if (sys_rst_o !== prev) begin
			report_mismatch({name, " one cycle"}, prev, sys_rst_o);
		end
		@(negedge CLK125);
		if (sys_rst_o !== exp_rst) begin
			report_mismatch(name, exp_rst, sys_rst_o);
		end
	endtask

	// Stim bits are pulse, mem_err, vme, cpld and inhibit
	task automatic check_leds(input string name, input logic [4:0] stim,
			input logic [LED_COUNT-1:0] exp_led);
		logic [3:0] base;
		int         k;
		@(negedge CLK125);
		base = {mem_err_i, vme_access_i, cpld_access_i, inhibit_i};
		@(posedge CLK125);
		{mem_err_i, vme_access_i, cpld_access_i, inhibit_i} <= stim[3:0];
		for (k = 0; k <= LED_HOLD + 4; k++) begin
			@(negedge CLK125);
			// Lit after 2 cycles and through the hold after a pulse
			if (k == 2 || (stim[4] && k > 2 && k <= LED_HOLD + 1)) begin
				if ((led_o & exp_led) !== exp_led) begin
					report_mismatch({name, " lit"}, exp_led, led_o);
				end
			end
			if (k == 0 && stim[4]) begin
				@(posedge CLK125);
				{mem_err_i, vme_access_i, cpld_access_i, inhibit_i} <= base;
			end
		end
		if (stim[4]) begin
			if ((led_o & exp_led) !== '0) begin
				report_mismatch({name, " dark"}, 0, led_o);
			end
		end else if (led_o !== exp_led) begin
			report_mismatch({name, " steady"}, exp_led, led_o);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin : main_seq
		int               fd;
		int               cnt;
		int               k;
		logic [8*8-1:0]   kind_v;
		logic [8*24-1:0]  name_v;
		logic [31:0]      stim_v;
		logic [31:0]      exp_v;
		logic [31:0]      rnd;
		string            line_s;
		token_word_t      w;
		rst_n_i       <= 1'b0;
		ser_trig_i    <= 1'b0;
		ext_rst_n_i   <= 1'b1;
		mem_err_i     <= 1'b0;
		vme_access_i  <= 1'b0;
		cpld_access_i <= 1'b0;
		inhibit_i     <= 1'b0;
		repeat (5) @(posedge CLK125);
		rst_n_i <= 1'b1;

		// Power-on hold with the CPLD line already high
		for (k = 0; k < STARTUP_CYCLES; k++) begin
			@(negedge CLK125);
			if (sys_rst_o !== 1'b1) begin
				report_mismatch("startup hold", 1, sys_rst_o);
			end
			if (k >= 2 && led_o[LED_ERR] !== 1'b1) begin
				report_mismatch("startup error LED", 1, led_o[LED_ERR]);
			end
		end
		k = 0;
		while (sys_rst_o !== 1'b0 && k < 10) begin
			@(negedge CLK125);
			k++;
		end
		if (sys_rst_o !== 1'b0) begin
			other_cnt++;
			$display("ERROR: system reset never released after the startup hold");
		end

		fd = $fopen("bench/wfd_ctrl_tests.txt", "r");
		if (fd == 0) begin
			other_cnt++;
			$display("ERROR: cannot open bench/wfd_ctrl_tests.txt");
		end else begin
			while ($fgets(line_s, fd) != 0) begin
				cnt = $sscanf(line_s, "%s %s %h %h", kind_v, name_v, stim_v, exp_v);
				if (cnt == 4 && kind_v != "#") begin
					if (kind_v == "TOKEN") begin
						send_frame($sformatf("%0s", name_v), stim_v[TOKEN_BITS-1:0],
							stim_v[TOKEN_BITS], exp_v[15:0]);
					end else if (kind_v == "RESET") begin
						apply_ext_reset($sformatf("%0s", name_v), stim_v[0], exp_v[0]);
					end else if (kind_v == "LED") begin
						check_leds($sformatf("%0s", name_v), stim_v[4:0],
							exp_v[LED_COUNT-1:0]);
					end else begin
						other_cnt++;
						$display("ERROR: unknown test kind in line %0s", line_s);
					end
				end
			end
			$fclose(fd);
		end

		// Extra tokens with roughly half of them bad in parity
		for (k = 0; k < RANDOM_TOKENS; k++) begin
			rnd = $random(seed);
			w.frame.tag   = TOKEN_TAG;
			w.frame.err   = rnd[20];
			w.frame.token = rnd[TOKEN_BITS-1:0];
			send_frame($sformatf("random_%0d", k), w.frame.token, w.frame.err, w.raw);
		end

		k = 0;
		while ((exp_word_q.size() != 0 || cyc <= err_led_due || cyc <= trig_led_due)
				&& k < 40) begin
			@(negedge CLK125);
			k++;
		end
		if (exp_word_q.size() != 0) begin
			other_cnt++;
			$display("ERROR: timed out waiting for token ready pulses");
		end

		$display("Errors: %0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/wfd_ctrl_tests.txt
# kind name stimulus expected, all values in hex
# TOKEN: stim bit 10 corrupts parity, bits 9:0 token; expected is the link word
TOKEN good_first 2a5 82a5
TOKEN good_zero 000 8000
TOKEN good_ones 3ff 83ff
TOKEN bad_parity 4a5 84a5
TOKEN b2b_first 155 8155
TOKEN b2b_second 2aa 82aa
TOKEN b2b_bad 7ff 87ff
TOKEN b2b_last 001 8001
TOKEN good_mid 1c3 81c3
# RESET: stim is the CPLD reset line level, expected is the system reset
RESET ext_assert 0 1
RESET ext_hold 0 1
RESET ext_release 1 0
RESET ext_idle 1 0
RESET ext_assert_again 0 1
RESET ext_release_again 1 0
# LED: stim bits pulse, mem_err, vme, cpld, inhibit; expected is the LED vector
LED idle_levels 00 8
LED vme_pulse 14 2
LED cpld_pulse 12 2
LED vme_level 04 a
LED vme_drop 00 8
LED inhibit_on 01 0
LED inhibit_off 00 8
LED mem_err_on 08 9
LED mem_err_off 00 8
LED mem_err_pulse 18 1

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
# The result comes from the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_wfd_ctrl -f src.f -o tb_wfd_ctrl \
	&& ./obj_dir/tb_wfd_ctrl | tee /dev/stderr | grep -x "Test passed" > /dev/null \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }

//--- src.f
src/wfd_pkg.sv
src/trig_token_rx.sv
src/startup_reset.sv
src/led_status.sv
src/wfd_ctrl_top.sv
bench/tb_wfd_ctrl.sv

//--- src/led_status.sv
`timescale 1ns/1ns
`default_nettype none

module led_status import wfd_pkg::*; #(
	parameter int LED_HOLD = 6250000
) (
	input  wire                  CLK125,
	input  wire                  rst_n_i,
	// From the reset controller
	input  wire                  sys_rst_i,
	// From the token receiver
	input  wire                  tok_rdy_i,
	input  wire                  tok_err_i,
	// Board status levels
	input  wire                  mem_err_i,
	input  wire                  vme_access_i,
	input  wire                  cpld_access_i,
	input  wire                  inhibit_i,
	// Front panel
	output logic [LED_COUNT-1:0] led_o
);

	// Counter must hold LED_HOLD itself
	localparam int HOLD_W = $clog2(LED_HOLD + 1);
	localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(LED_HOLD);

	logic [LED_COUNT-1:0] src_d;
	logic [LED_COUNT-1:0] src_q;

	//////////////////////////////
	// LED sources
	//////////////////////////////

	always_comb begin
		src_d = '0;
		// Memory error, reset or bad token
		src_d[LED_ERR]    = mem_err_i | sys_rst_i | tok_err_i;
		// Access to this card or to the CPLD
		src_d[LED_ACCESS] = vme_access_i | cpld_access_i;
		// Master trigger received
		src_d[LED_TRIG]   = tok_rdy_i;
		// Lit while no inhibit
		src_d[LED_NO_INH] = ~inhibit_i;
	end

	// One register stage for all sources
	always_ff @(posedge CLK125 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			src_q <= '0;
		end else begin
			src_q <= src_d;
		end
	end

	//////////////////////////////
	// Stretchers
	//////////////////////////////

	// Retriggerable hold per LED
	for (genvar i = 0; i < LED_COUNT; i++) begin : g_led
		logic [HOLD_W-1:0] hold_cnt;

		always_ff @(posedge CLK125 or negedge rst_n_i) begin
			if (!rst_n_i) begin
				hold_cnt <= '0;
			end else if (src_q[i]) begin
				// Reload while source is active
				hold_cnt <= HOLD_LOAD;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end

		// Lit as long as the hold runs
		assign led_o[i] = (hold_cnt != '0);
	end

endmodule

`default_nettype wire

//--- src/startup_reset.sv
`timescale 1ns/1ns
`default_nettype none

module startup_reset #(
	parameter int STARTUP_CYCLES = 1000000
) (
	input  wire  CLK125,
	input  wire  rst_n_i,
	// Global reset from the CPLD, asynchronous
	input  wire  ext_rst_n_i,
	// System reset, active high
	output logic sys_rst_o
);

	localparam int CNT_W = (STARTUP_CYCLES > 1) ? $clog2(STARTUP_CYCLES) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(STARTUP_CYCLES - 1);

	logic [CNT_W-1:0] hold_cnt;
	logic             hold_q;
	logic [1:0]       sync_q;

	//////////////////////////////
	// Power-on hold
	//////////////////////////////

	// Counts once after power-up and then stops
	always_ff @(posedge CLK125 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hold_cnt <= '0;
			hold_q   <= 1'b1;
		end else if (hold_q) begin
			if (hold_cnt == LAST_CNT) begin
				hold_q <= 1'b0;
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// CPLD reset follower
	//////////////////////////////

	// Two flops for the asynchronous line
	// The hold forces reset into the first stage
	always_ff @(posedge CLK125 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q <= 2'b11;
		end else begin
			sync_q[0] <= hold_q | ~ext_rst_n_i;
			sync_q[1] <= sync_q[0];
		end
	end

	assign sys_rst_o = sync_q[1];

endmodule

`default_nettype wire

//--- src/trig_token_rx.sv
`timescale 1ns/1ns
`default_nettype none

module trig_token_rx import wfd_pkg::*; (
	input  wire                   CLK125,
	input  wire                   rst_n_i,
	// Serial trigger line from the trigger FPGA
	input  wire                   ser_trig_i,
	// Received token and its status
	output logic [TOKEN_BITS-1:0] token_o,
	output logic                  tok_rdy_o,
	output logic                  tok_err_o,
	// Link word to the channel FPGAs
	output token_word_t           tx_word_o,
	output logic                  tx_k_o
);

	// Bit positions in a frame
	// 0 idle, 1 to TOKEN_BITS token bits, then parity
	localparam int CNT_W = $clog2(TOKEN_BITS + 2);
	localparam logic [CNT_W-1:0] PAR_POS = CNT_W'(TOKEN_BITS + 1);

	// Receiver state
	logic [CNT_W-1:0]      bit_cnt;
	logic                  in_data;
	logic                  par_acc;
	logic                  frame_done;
	logic                  frame_err;
	logic [TOKEN_BITS-1:0] shift_q;

	// Result register
	logic                  rdy_q;
	logic                  err_q;
	logic [TOKEN_BITS-1:0] token_q;

	//////////////////////////////
	// Frame receiver
	//////////////////////////////

	// Token bits follow the start bit
	assign in_data = (bit_cnt != '0) && (bit_cnt != PAR_POS);

	always_ff @(posedge CLK125 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bit_cnt    <= '0;
			par_acc    <= 1'b0;
			frame_done <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (bit_cnt == '0) begin
				// Line idles low, a high bit opens a frame
				if (ser_trig_i) begin
					bit_cnt <= CNT_W'(1);
					par_acc <= 1'b0;
				end
			end else if (bit_cnt == PAR_POS) begin
				// Odd parity over token and parity bit
				bit_cnt    <= '0;
				frame_done <= 1'b1;
				frame_err  <= ~(par_acc ^ ser_trig_i);
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
				par_acc <= par_acc ^ ser_trig_i;
			end
		end
	end

	// MSB arrives first
	always_ff @(posedge CLK125) begin
		if (in_data) begin
			shift_q <= {shift_q[TOKEN_BITS-2:0], ser_trig_i};
		end
	end

	//////////////////////////////
	// Result and link framing
	//////////////////////////////

	// Separate from the shifter so the next frame may already come in
	always_ff @(posedge CLK125 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdy_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			rdy_q <= frame_done;
			err_q <= frame_done & frame_err;
		end
	end

	// Token stays until the next frame completes
	always_ff @(posedge CLK125) begin
		if (frame_done) begin
			token_q <= shift_q;
		end
	end

	assign token_o   = token_q;
	assign tok_rdy_o = rdy_q;
	assign tok_err_o = err_q;

	// Data word only in the ready cycle
	assign tx_k_o = ~rdy_q;

	always_comb begin
		tx_word_o.raw = IDLE_COMMA;
		if (rdy_q) begin
			tx_word_o.frame.tag   = TOKEN_TAG;
			tx_word_o.frame.err   = err_q;
			tx_word_o.frame.token = token_q;
		end
	end

endmodule

`default_nettype wire

//--- src/wfd_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module wfd_ctrl_top import wfd_pkg::*; #(
	// Power-on hold in clock cycles
	parameter int STARTUP_CYCLES = 1000000,
	// LED stretch, 50 ms at 125 MHz
	parameter int LED_HOLD       = 6250000
) (
	input  wire                   CLK125,
	input  wire                   rst_n_i,
	// Inter-FPGA serial trigger
	input  wire                   ser_trig_i,
	// CPLD reset line, active low
	input  wire                   ext_rst_n_i,
	// Board status levels
	input  wire                   mem_err_i,
	input  wire                   vme_access_i,
	input  wire                   cpld_access_i,
	input  wire                   inhibit_i,
	// Token results
	output logic [TOKEN_BITS-1:0] token_o,
	output logic                  tok_rdy_o,
	output logic                  tok_err_o,
	// Link to channel FPGAs
	output token_word_t           tx_word_o,
	output logic                  tx_k_o,
	// System reset, active high
	output logic                  sys_rst_o,
	// Front panel LEDs
	output logic [LED_COUNT-1:0]  led_o
);

	//////////////////////////////
	// Token receiver
	//////////////////////////////

	trig_token_rx u_trig_token_rx (
		.CLK125     (CLK125),
		.rst_n_i    (rst_n_i),
		.ser_trig_i (ser_trig_i),
		.token_o    (token_o),
		.tok_rdy_o  (tok_rdy_o),
		.tok_err_o  (tok_err_o),
		.tx_word_o  (tx_word_o),
		.tx_k_o     (tx_k_o)
	);

	// Startup and CPLD reset
	startup_reset #(
		.STARTUP_CYCLES (STARTUP_CYCLES)
	) u_startup_reset (
		.CLK125      (CLK125),
		.rst_n_i     (rst_n_i),
		.ext_rst_n_i (ext_rst_n_i),
		.sys_rst_o   (sys_rst_o)
	);

	//////////////////////////////
	// Front panel indication
	//////////////////////////////

	led_status #(
		.LED_HOLD (LED_HOLD)
	) u_led_status (
		.CLK125        (CLK125),
		.rst_n_i       (rst_n_i),
		.sys_rst_i     (sys_rst_o),
		.tok_rdy_i     (tok_rdy_o),
		.tok_err_i     (tok_err_o),
		.mem_err_i     (mem_err_i),
		.vme_access_i  (vme_access_i),
		.cpld_access_i (cpld_access_i),
		.inhibit_i     (inhibit_i),
		.led_o         (led_o)
	);

endmodule

`default_nettype wire

//--- src/wfd_pkg.sv
`default_nettype none

package wfd_pkg;

	//////////////////////////////
	// Trigger token
	//////////////////////////////

	// Token bits carried by one serial frame
	localparam int TOKEN_BITS = 10;

	//////////////////////////////
	// Link word to channel FPGAs
	//////////////////////////////

	localparam int LINK_BITS = 16;
	localparam int TAG_BITS  = 5;

	// Marks a token frame on the link
	localparam logic [TAG_BITS-1:0] TOKEN_TAG = 5'b10000;

	// Idle K character when no token goes out
	localparam logic [LINK_BITS-1:0] IDLE_COMMA = 16'h00BC;

	// One link word, seen either raw or as a token frame
	typedef union packed {
		logic [LINK_BITS-1:0] raw;
		struct packed {
			logic [TAG_BITS-1:0]   tag;
			logic                  err;	// parity failed on the trigger line
			logic [TOKEN_BITS-1:0] token;
		} frame;
	} token_word_t;

	//////////////////////////////
	// Front panel LEDs
	//////////////////////////////

	localparam int LED_COUNT = 4;

	// Top to bottom on the panel
	localparam int LED_ERR    = 0;	// yellow
	localparam int LED_ACCESS = 1;
	localparam int LED_TRIG   = 2;
	localparam int LED_NO_INH = 3;

endpackage

`default_nettype wire
